// ==== bench/pce_io_checker.sv ====
`timescale 1ns/1ns

module pce_io_checker (
  input logic                     clk_sys_42_95,
  input pce_pkg::pad_nibble_t     joy_in,
  input pce_pkg::rom_addr_t       rom_wr_addr,
  input pce_pkg::rom_word_t       rom_wr_data,
  input logic                     rom_wr_toggle,
  input logic                     rom_populous,
  input pce_pkg::cd_host_packet_t host_packet,
  input pce_pkg::cd_stat_t        cd_stat,
  input logic                     cd_stat_get,
  input logic                     cd_dout_req,
  input logic                     cd_region,
  input logic [7:0]               cd_byte,
  input logic                     cd_byte_wr,
  input logic                     cd_dm
);
  import pce_pkg::*;

  int pass_count = 0;
  int fail_count = 0;
  int test_errors = 0;
  int test_index = 0;
  int get_cnt = 0;
  int req_cnt = 0;
  logic [7:0] bytes[$];

  // Sample strobes mid-cycle, away from the driving edge
  always @(negedge clk_sys_42_95) begin
    if (cd_stat_get) get_cnt++;
    if (cd_dout_req) req_cnt++;
    if (cd_byte_wr) bytes.push_back(cd_byte);
  end

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic clear_events();
    get_cnt = 0;
    req_cnt = 0;
    bytes.delete();
  endtask

  task automatic check_joy(input pad_nibble_t exp);
    compare("joy_in", joy_in, exp);
  endtask

  task automatic check_rom(input rom_addr_t exp_addr, input logic exp_tog,
                           input rom_word_t exp_data);
    compare("rom_wr_addr", rom_wr_addr, exp_addr);
    compare("rom_wr_toggle", rom_wr_toggle, exp_tog);
    compare("rom_wr_data", rom_wr_data, exp_data);
  endtask

  task automatic check_populous(input logic exp);
    compare("rom_populous", rom_populous, exp);
  endtask

  task automatic check_packet(input logic exp_tog, input logic [15:0] exp_kind,
                              input cd_comm_t exp_payload);
    compare("host_packet.toggle", host_packet.toggle, exp_tog);
    compare("host_packet.kind", host_packet.kind, exp_kind);
    compare("host_packet.payload", host_packet.payload, exp_payload);
  endtask

  task automatic check_reply(input cd_stat_t exp_stat, input logic exp_region,
                             input logic dout_flag);
    compare("cd_stat", cd_stat, exp_stat);
    compare("cd_region", cd_region, exp_region);
    compare("cd_stat_get pulses", get_cnt, dout_flag ? 0 : 1);
    compare("cd_dout_req pulses", req_cnt, dout_flag ? 1 : 0);
  endtask

  // Bytes go out low first, stopping at the header length
  task automatic check_feed(input int len, input logic dm, input logic [15:0] words[0:7]);
    logic [7:0] exp;
    compare("cd_dm", cd_dm, dm);
    if (bytes.size() != len) begin
      $display("Feed gave %0d byte pulses where %0d were expected", bytes.size(), len);
      test_errors++;
    end
    for (int i = 0; i < len && i < bytes.size(); i++) begin
      exp = (i % 2) ? words[i / 2][15:8] : words[i / 2][7:0];
      compare($sformatf("cd_byte[%0d]", i), bytes[i], exp);
    end
  endtask

  task automatic finish_test(input string label);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0d %s: ok", test_index, label);
    end else begin
      fail_count++;
      $display("test %0d %s: %0d mismatches", test_index, label, test_errors);
    end
    test_index++;
    test_errors = 0;
  endtask

endmodule

// ==== bench/pce_io_props.sv ====
`timescale 1ns/1ns

module pce_io_props (
  input logic                     clk_sys_42_95,
  input logic                     reset,
  input logic                     cd_comm_send,
  input logic                     cd_dout_send,
  input logic                     cd_dat_req,
  input logic                     cd_reset_req,
  input pce_pkg::cd_host_packet_t host_packet,
  input logic                     cd_stat_get,
  input logic                     cd_dout_req,
  input logic                     cd_byte_wr
);
  import pce_pkg::*;

  logic [3:0] req;
  int         assert_fails = 0;

  assign req = {cd_reset_req, cd_dat_req, cd_dout_send, cd_comm_send};

  // Status pulses are exclusive and one clock wide
  a_pulse_excl: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    !(cd_stat_get && cd_dout_req))
    else begin
      $error("status and data-out pulses overlap");
      assert_fails++;
    end
  a_stat_once: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    cd_stat_get |=> !cd_stat_get)
    else begin
      $error("cd_stat_get longer than one clock");
      assert_fails++;
    end
  a_dout_once: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    cd_dout_req |=> !cd_dout_req)
    else begin
      $error("cd_dout_req longer than one clock");
      assert_fails++;
    end

  // Packet toggle follows a request edge by one clock
  a_toggle_cause: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    $changed(host_packet.toggle) |-> (($past(req) & ~$past(req, 2)) != 4'd0))
    else begin
      $error("packet toggle moved without a request edge");
      assert_fails++;
    end

  a_byte_once: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    cd_byte_wr |=> !cd_byte_wr)
    else begin
      $error("cd_byte_wr longer than one clock");
      assert_fails++;
    end

endmodule

bind pce_io_top pce_io_props props (.*);

// ==== bench/tb_pce_io.sv ====
`timescale 1ns/1ns
`include "pce_cfg.svh"

module tb_pce_io;
  import pce_pkg::*;

  typedef enum {OP_PAD, OP_TAP, OP_SIX, OP_TURBO, OP_ROM, OP_CD_REQ, OP_CD_REPLY,
                OP_FEED} op_t;
  typedef struct {
    op_t         op;
    int          a;
    int          b;
    logic [31:0] expected;
  } entry_t;

  localparam int N_ENTRIES = 18;
  localparam int ROM_WORDS = 4248;

  logic clk_sys_42_95 = 1'b0;
  logic reset;
  pad_buttons_t [`PCE_PLAYERS-1:0] pads;
  logic six_button, tap_enable, joy_sel, joy_clr;
  turbo_speed_t turbo1_speed, turbo2_speed;
  pad_nibble_t joy_in;
  logic cart_download, ioctl_wr, rom_wr_toggle, rom_populous;
  rom_word_t ioctl_dout, rom_wr_data;
  rom_addr_t rom_wr_addr;
  logic cd_en, cd_comm_send, cd_dout_send, cd_dat_req, cd_reset_req;
  cd_comm_t cd_comm;
  cd_dout_t cd_dout;
  cd_host_reply_t host_reply;
  cd_host_packet_t host_packet;
  cd_stat_t cd_stat;
  logic cd_stat_get, cd_dout_req, cd_region;
  logic cd_dat_download, cdctl_wr, cd_byte_wr, cd_dm;
  rom_word_t cd_dat_word;
  logic [7:0] cd_byte;

  entry_t table_q[N_ENTRIES];
  logic table_ready = 1'b0;
  logic [15:0] lfsr_state = 16'd5742;
  int clr_count = 0;
  logic bank_model = 1'b0;
  logic rom_tog = 1'b0;
  logic pkt_tog = 1'b0;
  logic reply_tog = 1'b0;
  cd_comm_t payload_model;

  pce_io_top dut (.*);
  pce_io_checker chk (.*);

  always #10 clk_sys_42_95 = ~clk_sys_42_95;

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] draw(input int n);
    logic fb;
    draw = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      draw = {draw[30:0], fb};
    end
  endfunction

  function automatic logic turbo_on(input turbo_speed_t speed, input int cnt);
    if (speed == 2'd1) return cnt[2];
    if (speed == 2'd2) return cnt[1];
    return 1'b1;
  endfunction

  // Active-low pad word with turbo merged in
  function automatic pad_nibble_t model_nibble(input int p, input logic sel);
    pad_buttons_t b;
    logic [15:0] w;
    if (p >= `PCE_PLAYERS) begin
      w = 16'h0FFF;
    end else begin
      b = pads[p];
      if (!six_button) begin
        b.b1 = b.b1 | (b.b3 & turbo_on(turbo1_speed, clr_count));
        b.b2 = b.b2 | (b.b4 & turbo_on(turbo2_speed, clr_count));
      end
      w = {4'h0, ~b.b6, ~b.b5, ~b.b4, ~b.b3, ~b.left, ~b.down, ~b.right, ~b.up,
           ~b.start, ~b.select, ~b.b2, ~b.b1};
    end
    return w[{bank_model, sel, 2'b00} +: 4];
  endfunction

  function automatic rom_word_t rom_image(input rom_addr_t addr, input int corrupt);
    logic [3:0] lo;
    lo = addr[3:0];
    rom_image = addr[15:0] ^ 16'hA5C3;
    if (addr[23:4] == `PCE_POP_BANK_A || addr[23:4] == `PCE_POP_BANK_B) begin
      if (lo == 4'd6) rom_image = `PCE_POP_SIG_0;
      if (lo == 4'd8) rom_image = `PCE_POP_SIG_1;
      if (lo == 4'd10) rom_image = `PCE_POP_SIG_2;
      if (lo == 4'd12) rom_image = `PCE_POP_SIG_3;
    end
    if (addr == corrupt) rom_image = rom_image ^ 16'h0100;
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge clk_sys_42_95);
    #2;
  endtask

  task automatic clear_pulse();
    joy_clr = 1'b1;
    tick(3);
    joy_clr = 1'b0;
    clr_count++;
    bank_model = six_button ? ~bank_model : 1'b0;
    tick(3);
  endtask

  task automatic read_port(input int p);
    joy_sel = 1'b1;
    tick(3);
    chk.check_joy(model_nibble(p, 1'b1));
    joy_sel = 1'b0;
    tick(3);
    chk.check_joy(model_nibble(p, 1'b0));
  endtask

  task automatic random_pads();
    for (int i = 0; i < `PCE_PLAYERS; i++) pads[i] = pad_buttons_t'(draw(12));
  endtask

  task automatic run_rom(input entry_t e);
    rom_word_t word;
    cart_download = 1'b1;
    tick(2);
    for (int i = 0; i < e.a; i++) begin
      word = rom_image(rom_addr_t'(2 * i), e.b);
      ioctl_dout = word;
      ioctl_wr = 1'b1;
      tick(2);
      ioctl_wr = 1'b0;
      tick(2);
      rom_tog = ~rom_tog;
      chk.check_rom(rom_addr_t'(2 * (i + 1)), rom_tog, word);
    end
    chk.check_populous(e.expected[0]);
    cart_download = 1'b0;
    tick(2);
  endtask

  task automatic run_cd_req(input entry_t e);
    cd_en = e.b[0];
    cd_comm = {draw(32), draw(32), draw(32)};
    cd_dout = {16'(draw(16)), draw(32), draw(32)};
    {cd_reset_req, cd_dat_req, cd_dout_send, cd_comm_send} = e.a[3:0];
    tick(3);
    if (e.a[0]) payload_model = cd_comm;
    else if (e.a[1]) payload_model[79:0] = cd_dout;
    pkt_tog = ~pkt_tog;
    chk.check_packet(pkt_tog, e.expected[15:0], payload_model);
    {cd_reset_req, cd_dat_req, cd_dout_send, cd_comm_send} = 4'd0;
    tick(2);
  endtask

  task automatic run_feed(input entry_t e);
    logic [15:0] words[0:7];
    chk.clear_events();
    cd_dat_download = 1'b1;
    tick(2);
    cd_dat_word = {e.b[0], 15'(e.a)};
    cdctl_wr = 1'b1;
    tick(1);
    cdctl_wr = 1'b0;
    tick(2);
    // One extra word past the length must be ignored
    for (int i = 0; i < (e.a + 1) / 2 + 1; i++) begin
      words[i] = 16'(draw(16));
      cd_dat_word = words[i];
      cdctl_wr = 1'b1;
      tick(1);
      cdctl_wr = 1'b0;
      tick(6);
    end
    tick(4);
    chk.check_feed(e.expected, e.b[0], words);
    cd_dat_download = 1'b0;
    tick(2);
  endtask

  task automatic run_entry(input entry_t e);
    case (e.op)
      OP_PAD: begin
        random_pads();
        clear_pulse();
        read_port(0);
      end
      OP_TAP: begin
        tap_enable = 1'b1;
        random_pads();
        clear_pulse();
        chk.check_joy(model_nibble(0, 1'b0));
        for (int p = 1; p < `PCE_TAP_PORTS; p++) read_port(p);
        chk.check_joy(e.expected[3:0]);
        tap_enable = 1'b0;
      end
      OP_SIX: begin
        six_button = 1'b1;
        random_pads();
        repeat (2) begin
          clear_pulse();
          chk.check_joy(model_nibble(0, 1'b0));
          read_port(0);
        end
        six_button = 1'b0;
      end
      OP_TURBO: begin
        turbo1_speed = 2'd1;
        pads = '0;
        pads[0].b3 = 1'b1;
        repeat (e.a) begin
          clear_pulse();
          chk.check_joy({3'b111, ~clr_count[2]});
        end
        turbo1_speed = 2'd0;
      end
      OP_ROM: run_rom(e);
      OP_CD_REQ: run_cd_req(e);
      OP_CD_REPLY: begin
        chk.clear_events();
        reply_tog = ~reply_tog;
        host_reply = '{toggle: reply_tog, spare: '0, region: e.b[0], dout_flag: e.a[0],
                       stat: e.expected[15:0]};
        tick(4);
        chk.check_reply(e.expected[15:0], e.b[0], e.a[0]);
      end
      default: run_feed(e);
    endcase
    chk.finish_test(e.op.name());
  endtask

  initial begin
    table_q[0]  = '{OP_PAD, 0, 0, 0};
    table_q[1]  = '{OP_PAD, 0, 0, 0};
    table_q[2]  = '{OP_PAD, 0, 0, 0};
    table_q[3]  = '{OP_TAP, 0, 0, 32'hF};
    table_q[4]  = '{OP_SIX, 0, 0, 0};
    table_q[5]  = '{OP_TURBO, 16, 0, 0};
    table_q[6]  = '{OP_ROM, ROM_WORDS, 0, 1};
    table_q[7]  = '{OP_ROM, ROM_WORDS, 32'h1F2A, 0};
    table_q[8]  = '{OP_CD_REQ, 1, 1, 32'h8000};
    table_q[9]  = '{OP_CD_REQ, 2, 0, `PCE_CD_KIND_DOUT};
    table_q[10] = '{OP_CD_REQ, 4, 0, `PCE_CD_KIND_DATREQ};
    table_q[11] = '{OP_CD_REQ, 8, 0, `PCE_CD_KIND_RESET};
    table_q[12] = '{OP_CD_REQ, 3, 0, 32'h0000};
    table_q[13] = '{OP_CD_REQ, 12, 0, `PCE_CD_KIND_DATREQ};
    table_q[14] = '{OP_CD_REPLY, 0, 1, 32'h3412};
    table_q[15] = '{OP_CD_REPLY, 1, 0, 32'h00A5};
    table_q[16] = '{OP_FEED, 7, 1, 7};
    table_q[17] = '{OP_FEED, 4, 0, 4};
    table_ready = 1'b1;

    reset = 1'b1;
    pads = '0;
    {six_button, tap_enable, joy_sel, joy_clr} = 4'd0;
    turbo1_speed = 2'd0;
    turbo2_speed = 2'd0;
    {cart_download, ioctl_wr} = 2'd0;
    ioctl_dout = '0;
    {cd_en, cd_comm_send, cd_dout_send, cd_dat_req, cd_reset_req} = 5'd0;
    cd_comm = '0;
    cd_dout = '0;
    host_reply = '0;
    {cd_dat_download, cdctl_wr} = 2'd0;
    cd_dat_word = '0;
    tick(8);
    reset = 1'b0;
    tick(2);

    for (int i = 0; i < N_ENTRIES; i++) run_entry(table_q[i]);

    $display("Summary: %0d tests passed, %0d failed, %0d assertion failures",
             chk.pass_count, chk.fail_count, dut.props.assert_fails);
    if (chk.fail_count == 0 && dut.props.assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // ROM entries cost one step per word, the others a few
  initial begin
    int steps;
    wait (table_ready);
    steps = 0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      steps += (table_q[i].op == OP_ROM) ? table_q[i].a : 4;
    end
    repeat (steps * 40 + 200) @(posedge clk_sys_42_95);
    $display("Timeout: the tests did not finish in %0d clocks", steps * 40 + 200);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+src
src/pce_pkg.sv
src/pad_scanner.sv
src/rom_loader.sv
src/cd_link.sv
src/cd_sector_feed.sv
src/pce_io_top.sv
bench/pce_io_props.sv
bench/pce_io_checker.sv
bench/tb_pce_io.sv

// ==== src/cd_link.sv ====
`timescale 1ns/1ns
`include "pce_cfg.svh"

module cd_link (
  input  logic                     clk_sys_42_95,
  input  logic                     reset,
  input  logic                     cd_en,
  input  pce_pkg::cd_comm_t        cd_comm,
  input  logic                     cd_comm_send,
  input  pce_pkg::cd_dout_t        cd_dout,
  input  logic                     cd_dout_send,
  input  logic                     cd_dat_req,
  input  logic                     cd_reset_req,
  input  pce_pkg::cd_host_reply_t  host_reply,
  output pce_pkg::cd_host_packet_t host_packet,
  output pce_pkg::cd_stat_t        cd_stat,
  output logic                     cd_stat_get,
  output logic                     cd_dout_req,
  output logic                     cd_region
);
  import pce_pkg::*;

  logic        comm_q;
  logic        dout_q;
  logic        datreq_q;
  logic        rst_req_q;
  logic        reply_tog_q;
  logic        pkt_toggle;
  logic [15:0] pkt_kind;
  cd_comm_t    pkt_payload;
  logic        comm_rise;
  logic        dout_rise;
  logic        datreq_rise;
  logic        rst_rise;
  logic        reply_new;

  assign comm_rise   = cd_comm_send & ~comm_q;
  assign dout_rise   = cd_dout_send & ~dout_q;
  assign datreq_rise = cd_dat_req & ~datreq_q;
  assign rst_rise    = cd_reset_req & ~rst_req_q;
  assign reply_new   = host_reply.toggle != reply_tog_q;

  assign host_packet = '{toggle: pkt_toggle, kind: pkt_kind, payload: pkt_payload};

  // Edge history, toggles and strobes
  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      comm_q      <= 1'b0;
      dout_q      <= 1'b0;
      datreq_q    <= 1'b0;
      rst_req_q   <= 1'b0;
      reply_tog_q <= 1'b0;
      pkt_toggle  <= 1'b0;
      cd_stat_get <= 1'b0;
      cd_dout_req <= 1'b0;
      cd_region   <= 1'b0;
    end else begin
      comm_q      <= cd_comm_send;
      dout_q      <= cd_dout_send;
      datreq_q    <= cd_dat_req;
      rst_req_q   <= cd_reset_req;
      cd_stat_get <= 1'b0;
      cd_dout_req <= 1'b0;
      if (comm_rise || dout_rise || datreq_rise || rst_rise) begin
        pkt_toggle <= ~pkt_toggle;
      end
      if (reply_new) begin
        reply_tog_q <= host_reply.toggle;
        cd_stat_get <= ~host_reply.dout_flag;
        cd_dout_req <= host_reply.dout_flag;
        cd_region   <= host_reply.region;
      end
    end
  end

  // Packet body by request priority
  always_ff @(posedge clk_sys_42_95) begin
    if (comm_rise) begin
      pkt_payload <= cd_comm;
      pkt_kind    <= {cd_en, 15'd0};
    end else if (dout_rise) begin
      pkt_payload[79:0] <= cd_dout;
      pkt_kind          <= `PCE_CD_KIND_DOUT;
    end else if (datreq_rise) begin
      pkt_kind <= `PCE_CD_KIND_DATREQ;
    end else if (rst_rise) begin
      pkt_kind <= `PCE_CD_KIND_RESET;
    end
    if (reply_new) begin
      cd_stat <= host_reply.stat;
    end
  end

endmodule

// ==== src/cd_sector_feed.sv ====
`timescale 1ns/1ns

module cd_sector_feed (
  input  logic               clk_sys_42_95,
  input  logic               reset,
  input  logic               cd_dat_download,
  input  logic               cdctl_wr,
  input  pce_pkg::rom_word_t cd_dat_word,
  output logic [7:0]         cd_byte,
  output logic               cd_byte_wr,
  output logic               cd_dm
);
  import pce_pkg::*;

  feed_state_t feed;
  emit_state_t emit;
  cd_len_t     len;
  cd_len_t     cnt;
  cd_len_t     cnt_next;
  rom_word_t   data_q;
  logic        download_q;
  logic        strobe;
  logic        accept;

  assign strobe   = cdctl_wr & cd_dat_download;
  assign accept   = strobe && feed == FEED_DATA && cnt < len;
  assign cnt_next = cnt + 15'd1;
  assign cd_byte  = (emit == EMIT_HIGH) ? data_q[15:8] : data_q[7:0];

  always_ff @(posedge clk_sys_42_95) begin
    download_q <= cd_dat_download;
    if (reset || (cd_dat_download && !download_q)) begin
      feed       <= FEED_HEADER;
      emit       <= EMIT_IDLE;
      len        <= '0;
      cnt        <= '0;
      cd_byte_wr <= 1'b0;
      cd_dm      <= 1'b0;
    end else if (strobe && feed == FEED_HEADER) begin
      // Header word, mode flag over byte length
      {cd_dm, len} <= cd_dat_word;
      cnt          <= '0;
      feed         <= FEED_DATA;
    end else if (accept) begin
      emit <= EMIT_LOW;
    end else begin
      case (emit)
        EMIT_LOW, EMIT_HIGH: begin
          if (!cd_byte_wr) begin
            cd_byte_wr <= 1'b1;
          end else begin
            cd_byte_wr <= 1'b0;
            cnt        <= cnt_next;
            // Odd length ends on a low byte
            if (emit == EMIT_LOW && cnt_next < len) begin
              emit <= EMIT_HIGH;
            end else begin
              emit <= EMIT_IDLE;
            end
          end
        end
        default: emit <= EMIT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (accept) begin
      data_q <= cd_dat_word;
    end
  end

endmodule

// ==== src/pad_scanner.sv ====
`timescale 1ns/1ns
`include "pce_cfg.svh"

module pad_scanner (
  input  logic                                      clk_sys_42_95,
  input  logic                                      reset,
  input  pce_pkg::pad_buttons_t [`PCE_PLAYERS-1:0]  pads,
  input  logic                                      six_button,
  input  logic                                      tap_enable,
  input  pce_pkg::turbo_speed_t                     turbo1_speed,
  input  pce_pkg::turbo_speed_t                     turbo2_speed,
  input  logic                                      joy_sel,
  input  logic                                      joy_clr,
  output pce_pkg::pad_nibble_t                      joy_in
);
  import pce_pkg::*;

  logic [3:0]   turbo_cnt;
  logic         bank;
  tap_port_t    port;
  logic         sel_q;
  logic         clr_q;
  logic         gate1;
  logic         gate2;
  pad_buttons_t [`PCE_PLAYERS-1:0] merged;
  pad_word_t    port_word;

  // Slow speed on bit 2, fast on bit 1, else held solid
  function automatic logic turbo_gate(input turbo_speed_t speed, input logic [3:0] cnt);
    case (speed)
      2'd1:    turbo_gate = cnt[2];
      2'd2:    turbo_gate = cnt[1];
      default: turbo_gate = 1'b1;
    endcase
  endfunction

  // Active-low reply, d-pad reordered to left, down, right, up
  function automatic pad_word_t reply_word(input pad_buttons_t b);
    reply_word = {4'h0, ~{b.b6, b.b5, b.b4, b.b3}, ~{b.left, b.down, b.right, b.up},
                  ~{b.start, b.select, b.b2, b.b1}};
  endfunction

  assign gate1 = turbo_gate(turbo1_speed, turbo_cnt);
  assign gate2 = turbo_gate(turbo2_speed, turbo_cnt);

  // Turbo borrows b3 and b4 on three-button pads
  always_comb begin
    for (int i = 0; i < `PCE_PLAYERS; i++) begin
      merged[i] = pads[i];
      if (!six_button) begin
        merged[i].b1 = pads[i].b1 | (pads[i].b3 & gate1);
        merged[i].b2 = pads[i].b2 | (pads[i].b4 & gate2);
      end
    end
  end

  always_comb begin
    if (port < 3'(`PCE_PLAYERS)) begin
      port_word = reply_word(merged[port[1:0]]);
    end else begin
      // Empty tap socket and ports past it read as nothing pressed
      port_word = 16'h0FFF;
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      turbo_cnt <= '0;
      bank      <= 1'b0;
      port      <= '0;
      sel_q     <= 1'b0;
      clr_q     <= 1'b0;
      joy_in    <= '0;
    end else begin
      sel_q  <= joy_sel;
      clr_q  <= joy_clr;
      joy_in <= port_word[{bank, joy_sel, 2'b00} +: 4];
      if (joy_clr) begin
        port   <= '0;
        joy_in <= '0;
        if (!clr_q) begin
          turbo_cnt <= turbo_cnt + 4'd1;
          bank      <= ~bank & six_button;
        end
      end else if (joy_sel && !sel_q && tap_enable) begin
        port <= port + 3'd1;
      end
    end
  end

endmodule

// ==== src/pce_cfg.svh ====
`ifndef PCE_CFG_SVH
`define PCE_CFG_SVH

// Pad ports and multitap
`define PCE_PLAYERS      4
`define PCE_TAP_PORTS    5

// Cartridge download
`define PCE_ROM_ADDR_W   24
`define PCE_ROM_STEP     24'd2
`define PCE_HDR_BIT      9

// Populous bank patterns, address bits above the low four
`define PCE_POP_BANK_A   20'h212
`define PCE_POP_BANK_B   20'h1F2
`define PCE_POP_SIG_0    16'h4F50
`define PCE_POP_SIG_1    16'h5550
`define PCE_POP_SIG_2    16'h4F4C
`define PCE_POP_SIG_3    16'h5355

// Host packet kinds
`define PCE_CD_KIND_DOUT   16'h0001
`define PCE_CD_KIND_DATREQ 16'h0002
`define PCE_CD_KIND_RESET  16'h00FF

`endif

// ==== src/pce_io_top.sv ====
`timescale 1ns/1ns
`include "pce_cfg.svh"

module pce_io_top (
  input  logic                                      clk_sys_42_95,
  input  logic                                      reset,
  // Pads and multitap
  input  pce_pkg::pad_buttons_t [`PCE_PLAYERS-1:0]  pads,
  input  logic                                      six_button,
  input  logic                                      tap_enable,
  input  pce_pkg::turbo_speed_t                     turbo1_speed,
  input  pce_pkg::turbo_speed_t                     turbo2_speed,
  input  logic                                      joy_sel,
  input  logic                                      joy_clr,
  output pce_pkg::pad_nibble_t                      joy_in,
  // Cartridge download
  input  logic                                      cart_download,
  input  logic                                      ioctl_wr,
  input  pce_pkg::rom_word_t                        ioctl_dout,
  output pce_pkg::rom_addr_t                        rom_wr_addr,
  output pce_pkg::rom_word_t                        rom_wr_data,
  output logic                                      rom_wr_toggle,
  output logic                                      rom_populous,
  // CD host link
  input  logic                                      cd_en,
  input  pce_pkg::cd_comm_t                         cd_comm,
  input  logic                                      cd_comm_send,
  input  pce_pkg::cd_dout_t                         cd_dout,
  input  logic                                      cd_dout_send,
  input  logic                                      cd_dat_req,
  input  logic                                      cd_reset_req,
  input  pce_pkg::cd_host_reply_t                   host_reply,
  output pce_pkg::cd_host_packet_t                  host_packet,
  output pce_pkg::cd_stat_t                         cd_stat,
  output logic                                      cd_stat_get,
  output logic                                      cd_dout_req,
  output logic                                      cd_region,
  // Sector data
  input  logic                                      cd_dat_download,
  input  logic                                      cdctl_wr,
  input  pce_pkg::rom_word_t                        cd_dat_word,
  output logic [7:0]                                cd_byte,
  output logic                                      cd_byte_wr,
  output logic                                      cd_dm
);

  // Port names match the block ports one to one
  pad_scanner u_pad_scanner (.*);

  rom_loader u_rom_loader (.*);

  cd_link u_cd_link (.*);

  cd_sector_feed u_cd_sector_feed (.*);

endmodule

// ==== src/pce_pkg.sv ====
`include "pce_cfg.svh"

package pce_pkg;

  // Buttons of one pad, 1 means pressed
  typedef struct packed {
    logic b6;
    logic b5;
    logic b4;
    logic b3;
    logic start;
    logic select;
    logic b2;
    logic b1;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_buttons_t;

  typedef logic [15:0] pad_word_t;
  typedef logic [3:0]  pad_nibble_t;
  typedef logic [2:0]  tap_port_t;
  typedef logic [1:0]  turbo_speed_t;

  typedef logic [`PCE_ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;

  typedef logic [95:0] cd_comm_t;
  typedef logic [79:0] cd_dout_t;
  // Message in the high byte, status in the low byte
  typedef logic [15:0] cd_stat_t;
  typedef logic [14:0] cd_len_t;

  // Console to host
  typedef struct packed {
    logic        toggle;
    logic [15:0] kind;
    cd_comm_t    payload;
  } cd_host_packet_t;

  // Host to console
  typedef struct packed {
    logic        toggle;
    logic [93:0] spare;
    logic        region;
    logic        dout_flag;
    cd_stat_t    stat;
  } cd_host_reply_t;

  typedef enum logic {FEED_HEADER, FEED_DATA} feed_state_t;
  typedef enum logic [1:0] {EMIT_IDLE, EMIT_LOW, EMIT_HIGH} emit_state_t;

endpackage

// ==== src/rom_loader.sv ====
`timescale 1ns/1ns
`include "pce_cfg.svh"

module rom_loader (
  input  logic                clk_sys_42_95,
  input  logic                reset,
  input  logic                cart_download,
  input  logic                ioctl_wr,
  input  pce_pkg::rom_word_t  ioctl_dout,
  output pce_pkg::rom_addr_t  rom_wr_addr,
  output pce_pkg::rom_word_t  rom_wr_data,
  output logic                rom_wr_toggle,
  output logic                rom_populous
);
  import pce_pkg::*;

  logic       download_q;
  logic       wr_q;
  logic [1:0] populous;
  logic       bank_hit;
  logic       sig_slot;
  rom_word_t  sig_expect;

  assign rom_wr_data = ioctl_dout;
  assign bank_hit = (rom_wr_addr[23:4] == `PCE_POP_BANK_A) ||
                    (rom_wr_addr[23:4] == `PCE_POP_BANK_B);

  // Signature word expected at each checked offset
  always_comb begin
    sig_slot   = 1'b1;
    sig_expect = `PCE_POP_SIG_0;
    case (rom_wr_addr[3:0])
      4'd6:    sig_expect = `PCE_POP_SIG_0;
      4'd8:    sig_expect = `PCE_POP_SIG_1;
      4'd10:   sig_expect = `PCE_POP_SIG_2;
      4'd12:   sig_expect = `PCE_POP_SIG_3;
      default: sig_slot = 1'b0;
    endcase
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      download_q    <= 1'b0;
      wr_q          <= 1'b0;
      rom_wr_addr   <= '0;
      rom_wr_toggle <= 1'b0;
      populous      <= 2'b11;
    end else begin
      download_q <= cart_download;
      wr_q       <= ioctl_wr;
      if (cart_download && !download_q) begin
        rom_wr_addr <= '0;
        populous    <= 2'b11;
      end else if (ioctl_wr && !wr_q) begin
        rom_wr_toggle <= ~rom_wr_toggle;
        if (bank_hit && sig_slot && ioctl_dout != sig_expect) begin
          populous[rom_wr_addr[13]] <= 1'b0;
        end
      end else if (!ioctl_wr && wr_q) begin
        rom_wr_addr <= rom_wr_addr + `PCE_ROM_STEP;
      end
    end
  end

  // Flag for the bank the copier header would select
  assign rom_populous = populous[rom_wr_addr[`PCE_HDR_BIT]];

endmodule
